//--- swarm_core.f
+incdir+hdl
hdl/swarm_core_pkg.sv
hdl/core_bus_if.sv
hdl/core_task_fsm.sv
hdl/task_read_port.sv
hdl/core_write_staging.sv
hdl/task_child_counter.sv
hdl/swarm_core_adapter.sv
dv/swarm_core_adapter_asserts.sv
dv/swarm_core_adapter_tb.sv

//--- Bender.yml
package:
  name: swarm_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/swarm_core_pkg.sv
      - hdl/core_bus_if.sv
      - hdl/core_task_fsm.sv
      - hdl/task_read_port.sv
      - hdl/core_write_staging.sv
      - hdl/task_child_counter.sv
      - hdl/swarm_core_adapter.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/swarm_core_adapter_asserts.sv
      - dv/swarm_core_adapter_tb.sv

//--- dv/swarm_core_adapter_tb.sv
`timescale 1ns/1ps

`include "swarm_core_settings.svh"

module swarm_core_adapter_tb
   import swarm_core_pkg::*;
;

   localparam int TIMEOUT = 100;

   logic        clk;
   logic        rstn;
   logic        cmd_valid;
   logic        cmd_wr;
   logic [31:0] cmd_addr;
   logic [31:0] cmd_data;
   logic        cmd_ready;
   logic        rsp_valid;
   logic [31:0] rsp_data;
   logic        task_arvalid;
   logic        task_rvalid;
   task_t       task_rdata;
   cq_slot_t    task_rslot;
   thread_id_t  task_rthread;
   logic        task_wvalid;
   task_t       task_wdata;
   logic        task_wready;
   cq_slot_t    task_cq_slot;
   logic        start_task_valid;
   logic        start_task_ready;
   cq_slot_t    start_task_slot;
   logic        finish_task_valid;
   logic        finish_task_ready;
   cq_slot_t    finish_task_slot;
   thread_id_t  finish_task_thread;
   child_id_t   finish_task_num_children;
   logic        finish_task_undo_log_write;
   logic        undo_log_valid;
   logic        undo_log_ready;
   undo_id_t    undo_log_id;
   logic [31:0] undo_log_addr;
   logic [31:0] undo_log_data;
   cq_slot_t    undo_log_slot;

   task_t       cur_task;
   task_t       child;
   cq_slot_t    cur_slot;
   thread_id_t  cur_thread;
   int          children_sent;
   int          undo_sent;

   swarm_core_adapter dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic stop_run(input string why);
      $display("Test failed");
      $fatal(1, "%s", why);
   endtask

   task automatic expect_eq(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
      assert (actual === expected) else begin
         $display("** Error [%s] expected %0h, actual %0h", name, expected, actual);
         stop_run("value mismatch");
      end
   endtask

   // returns at the falling edge where sig is seen high
   task automatic wait_high(ref logic sig, input string what);
      int n;
      for (n = 0; n < TIMEOUT; n++) begin
         @(negedge clk);
         if (sig) break;
      end
      if (!sig) stop_run({"timeout waiting for ", what});
   endtask

   // entered and left 1 ns after a rising edge
   task automatic issue_cmd(input logic wr, input logic [31:0] addr, input logic [31:0] data);
      int n;
      cmd_valid = 1'b1;
      cmd_wr    = wr;
      cmd_addr  = addr;
      cmd_data  = data;
      for (n = 0; n < TIMEOUT; n++) begin
         @(negedge clk);
         if (cmd_ready) break;
      end
      if (!cmd_ready) stop_run("timeout waiting for cmd_ready");
      @(posedge clk);
      #1;
      cmd_valid = 1'b0;
   endtask

   task automatic read_field(input string name, input logic [31:0] addr,
                             input logic [31:0] expected);
      issue_cmd(1'b0, addr, 32'h0);
      @(negedge clk);
      expect_eq({name, " rsp_valid"}, 1, rsp_valid);
      expect_eq(name, expected, rsp_data);
      @(posedge clk);
      #1;
   endtask

   task automatic dequeue_new(input string name);
      cur_task.ts     = $urandom();
      cur_task.locale = $urandom();
      cur_task.ttype  = $urandom();
      cur_task.args   = {$urandom(), $urandom()};
      cur_slot        = $urandom();
      cur_thread      = $urandom();
      issue_cmd(1'b0, `SWARM_ADDR_DEQ_TASK, 32'h0);
      wait_high(task_arvalid, "task_arvalid");
      @(posedge clk);
      #1;
      task_rvalid  = 1'b1;
      task_rdata   = cur_task;
      task_rslot   = cur_slot;
      task_rthread = cur_thread;
      @(posedge clk);
      #1;
      task_rvalid = 1'b0;
      wait_high(start_task_valid, "start_task_valid");
      expect_eq({name, " start slot"}, cur_slot, start_task_slot);
      @(posedge clk);
      #1;
      start_task_ready = 1'b1;
      @(posedge clk);
      #1;
      start_task_ready = 1'b0;
      wait_high(rsp_valid, "dequeue response");
      expect_eq({name, " timestamp"}, cur_task.ts, rsp_data);
      @(posedge clk);
      #1;
      children_sent = 0;
      undo_sent     = 0;
   endtask

   task automatic send_undo(input logic [31:0] addr, input logic [31:0] data);
      issue_cmd(1'b1, `SWARM_ADDR_UNDO_ADDR, addr);
      issue_cmd(1'b1, `SWARM_ADDR_UNDO_DATA, data);
      wait_high(undo_log_valid, "undo_log_valid");
      expect_eq("undo id", undo_sent, undo_log_id);
      expect_eq("undo addr", addr, undo_log_addr);
      expect_eq("undo data", data, undo_log_data);
      expect_eq("undo slot", cur_slot, undo_log_slot);
      @(posedge clk);
      #1;
      undo_log_ready = 1'b1;
      @(posedge clk);
      #1;
      undo_log_ready = 1'b0;
      undo_sent++;
   endtask

   // pending means an enqueue is still waiting for task_wready
   task automatic report_finish(input bit pending);
      cmd_valid         = 1'b1;
      cmd_wr            = 1'b1;
      cmd_addr          = `SWARM_ADDR_FINISH;
      cmd_data          = 32'h0;
      finish_task_ready = 1'b1;
      if (pending) begin
         repeat (3) begin
            @(negedge clk);
            expect_eq("finish held back", 0, finish_task_valid);
         end
         @(posedge clk);
         #1;
         task_wready = 1'b1;
         children_sent++;
      end
      wait_high(finish_task_valid, "finish_task_valid");
      expect_eq("finish accept", 1, cmd_ready);
      expect_eq("finish slot", cur_slot, finish_task_slot);
      expect_eq("finish thread", cur_thread, finish_task_thread);
      expect_eq("finish children", children_sent, finish_task_num_children);
      expect_eq("finish undo flag", undo_sent != 0, finish_task_undo_log_write);
      @(posedge clk);
      #1;
      cmd_valid         = 1'b0;
      finish_task_ready = 1'b0;
      task_wready       = 1'b0;
   endtask

   always @(posedge clk) begin
      if (dut_i.asserts_i.err_count != 0) begin
         stop_run("a bound protocol assertion fired");
      end
   end

   initial begin
      void'($urandom(54));
      rstn              = 1'b0;
      cmd_valid         = 1'b0;
      cmd_wr            = 1'b0;
      cmd_addr          = 32'h0;
      cmd_data          = 32'h0;
      task_rvalid       = 1'b0;
      task_rdata        = '0;
      task_rslot        = '0;
      task_rthread      = '0;
      task_wready       = 1'b0;
      start_task_ready  = 1'b0;
      finish_task_ready = 1'b0;
      undo_log_ready    = 1'b0;
      children_sent     = 0;
      undo_sent         = 0;
      repeat (4) @(posedge clk);
      #1;
      rstn = 1'b1;

      @(negedge clk);
      expect_eq("reset task_arvalid", 0, task_arvalid);
      expect_eq("reset start_task_valid", 0, start_task_valid);
      expect_eq("reset finish_task_valid", 0, finish_task_valid);
      expect_eq("reset task_wvalid", 0, task_wvalid);
      expect_eq("reset undo_log_valid", 0, undo_log_valid);
      expect_eq("reset rsp_valid", 0, rsp_valid);
      @(posedge clk);
      #1;
      read_field("unmapped read", 32'hc000_0100, 32'h0);
      issue_cmd(1'b1, 32'hc000_0104, 32'hdead_beef);

      dequeue_new("first dequeue");
      read_field("locale read", `SWARM_ADDR_LOCALE, cur_task.locale);
      read_field("ttype read", `SWARM_ADDR_TTYPE, {28'h0, cur_task.ttype});
      read_field("arg0 read", `SWARM_ADDR_ARG0, cur_task.args[31:0]);
      read_field("arg1 read", `SWARM_ADDR_ARG1, cur_task.args[63:32]);

      child.ts     = $urandom();
      child.locale = $urandom();
      child.ttype  = $urandom();
      child.args   = {$urandom(), $urandom()};
      issue_cmd(1'b1, `SWARM_ADDR_LOCALE, child.locale);
      issue_cmd(1'b1, `SWARM_ADDR_TTYPE, {28'h0, child.ttype});
      issue_cmd(1'b1, `SWARM_ADDR_ARG0, child.args[31:0]);
      issue_cmd(1'b1, `SWARM_ADDR_ARG1, child.args[63:32]);
      issue_cmd(1'b1, `SWARM_ADDR_DEQ_TASK, child.ts);
      @(negedge clk);
      expect_eq("enqueue valid", 1, task_wvalid);
      expect_eq("enqueue ts", child.ts, task_wdata.ts);
      expect_eq("enqueue locale", child.locale, task_wdata.locale);
      expect_eq("enqueue ttype", child.ttype, task_wdata.ttype);
      expect_eq("enqueue args", child.args, task_wdata.args);
      expect_eq("enqueue slot", cur_slot, task_cq_slot);

      // a field write must stall while the enqueue waits for task_wready
      @(posedge clk);
      #1;
      cmd_valid = 1'b1;
      cmd_wr    = 1'b1;
      cmd_addr  = `SWARM_ADDR_LOCALE;
      cmd_data  = ~child.locale;
      repeat (4) begin
         @(negedge clk);
         expect_eq("enqueue held", 1, task_wvalid);
         expect_eq("field write stalled", 0, cmd_ready);
      end
      @(posedge clk);
      #1;
      task_wready = 1'b1;
      @(posedge clk);
      #1;
      task_wready = 1'b0;
      children_sent++;
      issue_cmd(1'b1, `SWARM_ADDR_LOCALE, ~child.locale);

      send_undo($urandom(), $urandom());
      send_undo($urandom(), $urandom());

      issue_cmd(1'b1, `SWARM_ADDR_DEQ_TASK, $urandom());
      report_finish(1'b1);

      dequeue_new("second dequeue");
      report_finish(1'b0);

      repeat (2) @(posedge clk);
      if (dut_i.asserts_i.err_count == 0) begin
         $display("Test passed");
         $finish;
      end else begin
         stop_run("a bound protocol assertion fired");
      end
   end

endmodule

//--- dv/swarm_core_adapter_asserts.sv
`timescale 1ns/1ps

module swarm_core_adapter_asserts (
   input logic clk,
   input logic rstn,
   input logic task_wvalid,
   input logic task_wready,
   input logic undo_log_valid,
   input logic undo_log_ready,
   input logic finish_task_valid,
   input logic rsp_valid
);

   // number of protocol failures seen so far
   int unsigned err_count = 0;

   property hold_until_ready(valid, ready);
      @(posedge clk) disable iff (!rstn) valid && !ready |=> valid;
   endproperty

   enq_hold_a: assert property (hold_until_ready(task_wvalid, task_wready))
      else begin
         $error("task_wvalid dropped before task_wready");
         err_count++;
      end

   undo_hold_a: assert property (hold_until_ready(undo_log_valid, undo_log_ready))
      else begin
         $error("undo_log_valid dropped before undo_log_ready");
         err_count++;
      end

   // finish goes out only once enqueue and undo traffic has drained
   finish_alone_a: assert property (@(posedge clk) disable iff (!rstn)
      finish_task_valid |-> !task_wvalid && !undo_log_valid)
      else begin
         $error("finish_task_valid overlaps a pending enqueue or undo record");
         err_count++;
      end

   rsp_pulse_a: assert property (@(posedge clk) disable iff (!rstn)
      rsp_valid |=> !rsp_valid)
      else begin
         $error("rsp_valid held for two cycles");
         err_count++;
      end

   reset_idle_a: assert property (@(posedge clk)
      !rstn |=> !task_wvalid && !undo_log_valid && !finish_task_valid && !rsp_valid)
      else begin
         $error("control outputs not idle after reset");
         err_count++;
      end

endmodule

bind swarm_core_adapter swarm_core_adapter_asserts asserts_i (
   .clk               (clk),
   .rstn              (rstn),
   .task_wvalid       (task_wvalid),
   .task_wready       (task_wready),
   .undo_log_valid    (undo_log_valid),
   .undo_log_ready    (undo_log_ready),
   .finish_task_valid (finish_task_valid),
   .rsp_valid         (rsp_valid)
);

//--- hdl/swarm_core_adapter.sv
`timescale 1ns/1ps

module swarm_core_adapter
   import swarm_core_pkg::*;
(
   input  logic        clk,
   input  logic        rstn,

   // processor data bus
   input  logic        cmd_valid,
   input  logic        cmd_wr,
   input  logic [31:0] cmd_addr,
   input  logic [31:0] cmd_data,
   output logic        cmd_ready,
   output logic        rsp_valid,
   output logic [31:0] rsp_data,

   // task dequeue
   output logic        task_arvalid,
   input  logic        task_rvalid,
   input  task_t       task_rdata,
   input  cq_slot_t    task_rslot,
   input  thread_id_t  task_rthread,

   // task enqueue
   output logic        task_wvalid,
   output task_t       task_wdata,
   input  logic        task_wready,
   output cq_slot_t    task_cq_slot,

   output logic        start_task_valid,
   input  logic        start_task_ready,
   output cq_slot_t    start_task_slot,

   output logic        finish_task_valid,
   input  logic        finish_task_ready,
   output cq_slot_t    finish_task_slot,
   output thread_id_t  finish_task_thread,
   output child_id_t   finish_task_num_children,
   output logic        finish_task_undo_log_write,

   // undo log
   output logic        undo_log_valid,
   input  logic        undo_log_ready,
   output undo_id_t    undo_log_id,
   output logic [31:0] undo_log_addr,
   output logic [31:0] undo_log_data,
   output cq_slot_t    undo_log_slot
);

   core_bus_if bus ();

   logic     write_taken;
   logic     deq_fire;
   cq_slot_t cq_slot;

   assign bus.cmd_valid = cmd_valid;
   assign bus.cmd_wr    = cmd_wr;
   assign bus.cmd_addr  = cmd_addr;
   assign bus.cmd_data  = cmd_data;
   assign cmd_ready     = bus.cmd_ready;

   // every outgoing message is tagged with the running task's slot
   assign task_cq_slot     = cq_slot;
   assign start_task_slot  = cq_slot;
   assign finish_task_slot = cq_slot;
   assign undo_log_slot    = cq_slot;

   core_task_fsm fsm_i (
      .clk                (clk),
      .rstn               (rstn),
      .bus                (bus.fsm),
      .write_taken        (write_taken),
      .task_arvalid       (task_arvalid),
      .task_rvalid        (task_rvalid),
      .task_rslot         (task_rslot),
      .task_rthread       (task_rthread),
      .start_task_valid   (start_task_valid),
      .start_task_ready   (start_task_ready),
      .finish_task_valid  (finish_task_valid),
      .finish_task_ready  (finish_task_ready),
      .task_wvalid        (task_wvalid),
      .undo_log_valid     (undo_log_valid),
      .deq_fire           (deq_fire),
      .cq_slot            (cq_slot),
      .finish_task_thread (finish_task_thread),
      .rsp_valid          (rsp_valid)
   );

   task_read_port read_i (
      .clk        (clk),
      .rstn       (rstn),
      .bus        (bus.reader),
      .deq_fire   (deq_fire),
      .task_rdata (task_rdata),
      .rsp_data   (rsp_data)
   );

   core_write_staging staging_i (
      .clk            (clk),
      .rstn           (rstn),
      .bus            (bus.staging),
      .write_taken    (write_taken),
      .task_wvalid    (task_wvalid),
      .task_wdata     (task_wdata),
      .task_wready    (task_wready),
      .undo_log_valid (undo_log_valid),
      .undo_log_addr  (undo_log_addr),
      .undo_log_data  (undo_log_data),
      .undo_log_ready (undo_log_ready)
   );

   task_child_counter counter_i (
      .clk            (clk),
      .rstn           (rstn),
      .deq_fire       (deq_fire),
      .task_wvalid    (task_wvalid),
      .task_wready    (task_wready),
      .undo_log_valid (undo_log_valid),
      .undo_log_ready (undo_log_ready),
      .num_children   (finish_task_num_children),
      .undo_log_id    (undo_log_id),
      .undo_written   (finish_task_undo_log_write)
   );

endmodule

//--- hdl/task_child_counter.sv
`timescale 1ns/1ps

module task_child_counter
   import swarm_core_pkg::*;
(
   input  logic      clk,
   input  logic      rstn,

   input  logic      deq_fire,

   input  logic      task_wvalid,
   input  logic      task_wready,
   input  logic      undo_log_valid,
   input  logic      undo_log_ready,

   output child_id_t num_children,
   output undo_id_t  undo_log_id,
   output logic      undo_written
);

   logic enq_hs;
   logic undo_hs;

   assign enq_hs  = task_wvalid & task_wready;
   assign undo_hs = undo_log_valid & undo_log_ready;

   // counts restart with every dequeued task
   always_ff @(posedge clk) begin
      if (!rstn || deq_fire) begin
         num_children <= '0;
         undo_log_id  <= '0;
         undo_written <= 1'b0;
      end else begin
         if (enq_hs) begin
            num_children <= num_children + 1'b1;
         end
         if (undo_hs) begin
            undo_log_id  <= undo_log_id + 1'b1;
            undo_written <= 1'b1;
         end
      end
   end

endmodule

//--- hdl/core_write_staging.sv
`timescale 1ns/1ps

module core_write_staging
   import swarm_core_pkg::*;
(
   input  logic        clk,
   input  logic        rstn,

   core_bus_if.staging bus,
   output logic        write_taken,

   output logic        task_wvalid,
   output task_t       task_wdata,
   input  logic        task_wready,

   output logic        undo_log_valid,
   output logic [31:0] undo_log_addr,
   output logic [31:0] undo_log_data,
   input  logic        undo_log_ready
);

   core_reg_e wr_reg;
   logic      wr_cmd;
   logic      enq_launch;
   logic      undo_launch;

   assign wr_reg = decode_core_addr(bus.cmd_addr);
   assign wr_cmd = bus.cmd_valid & bus.cmd_wr;

   // task fields stall while an enqueue is pending
   // undo registers stall while a record is pending
   always_comb begin
      write_taken = 1'b0;
      if (wr_cmd) begin
         case (wr_reg)
            REG_TS, REG_LOCALE, REG_TTYPE, REG_ARG0, REG_ARG1:
               write_taken = !task_wvalid;
            REG_UNDO_ADDR, REG_UNDO_DATA:
               write_taken = !undo_log_valid;
            REG_FINISH:
               write_taken = 1'b0;
            // unmapped writes are dropped
            default:
               write_taken = 1'b1;
         endcase
      end
   end

   assign enq_launch  = write_taken & (wr_reg == REG_TS);
   assign undo_launch = write_taken & (wr_reg == REG_UNDO_DATA);

   always_ff @(posedge clk) begin
      if (write_taken) begin
         case (wr_reg)
            REG_TS:        task_wdata.ts          <= bus.cmd_data;
            REG_LOCALE:    task_wdata.locale      <= bus.cmd_data;
            REG_TTYPE:     task_wdata.ttype       <= bus.cmd_data[$bits(task_wdata.ttype)-1:0];
            REG_ARG0:      task_wdata.args[31:0]  <= bus.cmd_data;
            REG_ARG1:      task_wdata.args[63:32] <= bus.cmd_data;
            REG_UNDO_ADDR: undo_log_addr          <= bus.cmd_data;
            REG_UNDO_DATA: undo_log_data          <= bus.cmd_data;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_wvalid <= 1'b0;
      end else if (enq_launch) begin
         task_wvalid <= 1'b1;
      end else if (task_wready) begin
         task_wvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         undo_log_valid <= 1'b0;
      end else if (undo_launch) begin
         undo_log_valid <= 1'b1;
      end else if (undo_log_ready) begin
         undo_log_valid <= 1'b0;
      end
   end

endmodule

//--- hdl/task_read_port.sv
`timescale 1ns/1ps

`include "swarm_core_settings.svh"

module task_read_port
   import swarm_core_pkg::*;
(
   input  logic        clk,
   input  logic        rstn,

   core_bus_if.reader  bus,

   input  logic        deq_fire,
   input  task_t       task_rdata,

   output logic [31:0] rsp_data
);

   task_t       task_q;
   logic [31:0] rd_addr;
   logic        rd_accept;

   assign rd_accept = bus.cmd_valid & bus.cmd_ready & !bus.cmd_wr;

   always_ff @(posedge clk) begin
      if (deq_fire) begin
         task_q <= task_rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_addr <= '0;
      end else if (rd_accept) begin
         rd_addr <= bus.cmd_addr;
      end
   end

   // held steady from acceptance until the response cycle
   always_comb begin
      case (decode_core_addr(rd_addr))
         REG_TS:     rsp_data = task_q.ts;
         REG_LOCALE: rsp_data = task_q.locale;
         REG_TTYPE:  rsp_data = {{(32-`SWARM_TTYPE_W){1'b0}}, task_q.ttype};
         REG_ARG0:   rsp_data = task_q.args[31:0];
         REG_ARG1:   rsp_data = task_q.args[63:32];
         default:    rsp_data = '0;
      endcase
   end

endmodule

//--- hdl/core_task_fsm.sv
`timescale 1ns/1ps

module core_task_fsm
   import swarm_core_pkg::*;
(
   input  logic       clk,
   input  logic       rstn,

   core_bus_if.fsm    bus,
   input  logic       write_taken,

   output logic       task_arvalid,
   input  logic       task_rvalid,
   input  cq_slot_t   task_rslot,
   input  thread_id_t task_rthread,

   output logic       start_task_valid,
   input  logic       start_task_ready,

   output logic       finish_task_valid,
   input  logic       finish_task_ready,

   input  logic       task_wvalid,
   input  logic       undo_log_valid,

   output logic       deq_fire,
   output cq_slot_t   cq_slot,
   output thread_id_t finish_task_thread,
   output logic       rsp_valid
);

   core_state_e state, state_next;
   core_reg_e   cmd_reg;
   logic        rd_cmd;
   logic        fin_cmd;
   logic        fin_fire;

   assign cmd_reg = decode_core_addr(bus.cmd_addr);
   assign rd_cmd  = bus.cmd_valid & !bus.cmd_wr;
   assign fin_cmd = bus.cmd_valid & bus.cmd_wr & (cmd_reg == REG_FINISH);

   assign task_arvalid     = (state == NEXT_TASK);
   assign deq_fire         = task_arvalid & task_rvalid;
   assign start_task_valid = (state == INFORM_CQ);
   assign rsp_valid        = (state == IO_READ);

   // finish waits until every staged enqueue and undo record has drained
   assign finish_task_valid = (state == FINISH_TASK) & !task_wvalid & !undo_log_valid;
   assign fin_fire          = finish_task_valid & finish_task_ready;

   assign bus.cmd_ready = ((state == WAIT_CORE) & rd_cmd) |
                          ((state == FINISH_TASK) & fin_cmd & fin_fire) |
                          write_taken;

   always_comb begin
      state_next = state;
      case (state)
         WAIT_CORE: begin
            if (rd_cmd) begin
               state_next = (cmd_reg == REG_TS) ? NEXT_TASK : IO_READ;
            end else if (fin_cmd) begin
               state_next = FINISH_TASK;
            end
         end
         NEXT_TASK: begin
            if (task_rvalid) begin
               state_next = INFORM_CQ;
            end
         end
         INFORM_CQ: begin
            if (start_task_ready) begin
               state_next = IO_READ;
            end
         end
         IO_READ: state_next = WAIT_CORE;
         FINISH_TASK: begin
            if (fin_fire) begin
               state_next = WAIT_CORE;
            end
         end
         default: state_next = WAIT_CORE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= WAIT_CORE;
      end else begin
         state <= state_next;
      end
   end

   // slot and thread of the running task
   always_ff @(posedge clk) begin
      if (deq_fire) begin
         cq_slot            <= task_rslot;
         finish_task_thread <= task_rthread;
      end
   end

endmodule

//--- hdl/core_bus_if.sv
`timescale 1ns/1ps

interface core_bus_if;

   logic        cmd_valid;
   logic        cmd_wr;
   logic [31:0] cmd_addr;
   logic [31:0] cmd_data;
   logic        cmd_ready;

   // only the fsm drives the ready
   modport fsm (
      input  cmd_valid, cmd_wr, cmd_addr, cmd_data,
      output cmd_ready
   );

   modport staging (
      input cmd_valid, cmd_wr, cmd_addr, cmd_data, cmd_ready
   );

   modport reader (
      input cmd_valid, cmd_wr, cmd_addr, cmd_data, cmd_ready
   );

endinterface

//--- hdl/swarm_core_pkg.sv
package swarm_core_pkg;

`include "swarm_core_settings.svh"

   typedef struct packed {
      logic [`SWARM_TS_W-1:0]     ts;
      logic [`SWARM_LOCALE_W-1:0] locale;
      logic [`SWARM_TTYPE_W-1:0]  ttype;
      logic [`SWARM_ARG_W-1:0]    args;
   } task_t;

   typedef logic [`SWARM_SLOT_W-1:0]    cq_slot_t;
   typedef logic [`SWARM_THREAD_W-1:0]  thread_id_t;
   typedef logic [`SWARM_CHILD_W-1:0]   child_id_t;
   typedef logic [`SWARM_UNDO_ID_W-1:0] undo_id_t;

   typedef enum logic [2:0] {
      WAIT_CORE, NEXT_TASK, INFORM_CQ, IO_READ, FINISH_TASK
   } core_state_e;

   typedef enum logic [3:0] {
      REG_TS, REG_LOCALE, REG_TTYPE, REG_ARG0, REG_ARG1,
      REG_UNDO_ADDR, REG_UNDO_DATA, REG_FINISH, REG_NONE
   } core_reg_e;

   // the dequeue address doubles as the timestamp register
   function automatic core_reg_e decode_core_addr(input logic [31:0] addr);
      case (addr)
         `SWARM_ADDR_DEQ_TASK:  return REG_TS;
         `SWARM_ADDR_LOCALE:    return REG_LOCALE;
         `SWARM_ADDR_TTYPE:     return REG_TTYPE;
         `SWARM_ADDR_ARG0:      return REG_ARG0;
         `SWARM_ADDR_ARG1:      return REG_ARG1;
         `SWARM_ADDR_UNDO_ADDR: return REG_UNDO_ADDR;
         `SWARM_ADDR_UNDO_DATA: return REG_UNDO_DATA;
         `SWARM_ADDR_FINISH:    return REG_FINISH;
         default:               return REG_NONE;
      endcase
   endfunction

endpackage

//--- hdl/swarm_core_settings.svh
`ifndef SWARM_CORE_SETTINGS_SVH
`define SWARM_CORE_SETTINGS_SVH

// task field widths
`define SWARM_TS_W        32
`define SWARM_LOCALE_W    32
`define SWARM_TTYPE_W     4
`define SWARM_ARG_W       64

// commit queue and bookkeeping widths
`define SWARM_SLOT_W      6
`define SWARM_THREAD_W    4
`define SWARM_CHILD_W     4
`define SWARM_UNDO_ID_W   4

// memory-mapped registers seen by the core data bus
`define SWARM_ADDR_DEQ_TASK   32'hc000_0000
`define SWARM_ADDR_LOCALE     32'hc000_0004
`define SWARM_ADDR_TTYPE      32'hc000_0008
`define SWARM_ADDR_ARG0       32'hc000_000c
`define SWARM_ADDR_ARG1       32'hc000_0010
`define SWARM_ADDR_UNDO_ADDR  32'hc000_0020
`define SWARM_ADDR_UNDO_DATA  32'hc000_0024
`define SWARM_ADDR_FINISH     32'hc000_0030

`endif
